/* all.f */
+incdir+src
src/hub75_pkg.sv
src/framebuffer_ram.sv
src/scan_control.sv
src/framebuffer_fetch.sv
src/pixel_encoder.sv
src/hub75_top.sv
tb/hub75_checker.sv
tb/hub75_tb.sv

/* run.sh */
#!/bin/sh
# build the hub75 testbench with verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f all.f --top-module hub75_tb -o hub75_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/hub75_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || grep -q "TEST RESULT: PASS" sim.log

/* src/framebuffer_fetch.sv */
////////////////////////////////////////////////////////////
// pixel fetch: ram address, load countdown, pair capture
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "hub75_params.svh"

module framebuffer_fetch (
    input  logic                   reset,
    input  logic                   clk_in,
    input  hub75_pkg::col_addr_t   column_address,
    input  hub75_pkg::row_addr_t   row_address,
    input  logic                   pixel_load_start,
    input  hub75_pkg::pixel_pair_t ram_data_in,
    output hub75_pkg::fb_addr_t    ram_address,
    output logic                   ram_clk_enable,
    output hub75_pkg::pixel_pair_t pixel_pair,
    output logic                   pixel_valid
);

    logic [1:0] load_count;

    assign ram_address = '{row: row_address, col: column_address};
    assign ram_clk_enable = (load_count != 2'd0);

    // countdown of one load
    always_ff @(posedge clk_in) begin
        if (reset) begin
            load_count <= 2'd0;
        end else if (pixel_load_start) begin
            load_count <= 2'(`HUB75_FETCH_COUNT);
        end else if (load_count != 2'd0) begin
            load_count <= load_count - 2'd1;
        end
    end

    // ram word is ready at count 2
    always_ff @(posedge clk_in) begin
        if (reset) begin
            pixel_pair <= '0;
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= (load_count == 2'd2);
            if (load_count == 2'd2) begin
                pixel_pair <= ram_data_in;
            end
        end
    end

    // scan side must keep loads apart
    one_load_in_flight: assert property (@(posedge clk_in) disable iff (reset)
        pixel_load_start |-> (load_count == 2'd0));

endmodule

/* src/framebuffer_ram.sv */
////////////////////////////////////////////////////////////
// framebuffer ram, host write port and registered read
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module framebuffer_ram (
    input  logic                   clk_in,
    input  logic                   wr_en,
    input  hub75_pkg::fb_addr_t    wr_addr,
    input  hub75_pkg::pixel_pair_t wr_data,
    input  logic                   rd_en,
    input  hub75_pkg::fb_addr_t    rd_addr,
    output hub75_pkg::pixel_pair_t rd_data
);

    localparam int DEPTH = 2 ** $bits(hub75_pkg::fb_addr_t);

    hub75_pkg::pixel_pair_t mem [DEPTH];

    // host side
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, old word on a collision
    always_ff @(posedge clk_in) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* src/hub75_params.svh */
////////////////////////////////////////////////////////////
// hub75 panel driver sizes and timing constants
////////////////////////////////////////////////////////////

`ifndef HUB75_PARAMS_SVH
`define HUB75_PARAMS_SVH

// panel geometry, both halves scanned together
`define HUB75_PANEL_WIDTH 64
`define HUB75_HALF_HEIGHT 16

// bits per colour channel, also the number of bit planes
`define HUB75_COLOR_BITS 4

// load countdown start, ram word is captured at count 2
`define HUB75_FETCH_COUNT 3

// led on-time of plane 0 in cycles, doubles per plane
`define HUB75_ON_BASE 8

`endif

/* src/hub75_pkg.sv */
////////////////////////////////////////////////////////////
// hub75 shared types: addresses, pixels, scan states
////////////////////////////////////////////////////////////

`include "hub75_params.svh"

package hub75_pkg;

    typedef logic [$clog2(`HUB75_PANEL_WIDTH)-1:0] col_addr_t;
    typedef logic [$clog2(`HUB75_HALF_HEIGHT)-1:0] row_addr_t;
    typedef logic [$clog2(`HUB75_COLOR_BITS)-1:0] plane_t;

    // rgb444, red in the top bits
    typedef struct packed {
        logic [`HUB75_COLOR_BITS-1:0] red;
        logic [`HUB75_COLOR_BITS-1:0] green;
        logic [`HUB75_COLOR_BITS-1:0] blue;
    } rgb_pixel_t;

    // one ram word holds both halves of a column
    typedef struct packed {
        rgb_pixel_t bottom;
        rgb_pixel_t top;
    } pixel_pair_t;

    // row in the upper bits
    typedef struct packed {
        row_addr_t row;
        col_addr_t col;
    } fb_addr_t;

    typedef enum logic [1:0] {
        SHIFT,
        BLANK,
        LATCH,
        DISPLAY
    } scan_state_t;

endpackage

/* src/hub75_top.sv */
////////////////////////////////////////////////////////////
// hub75 panel driver, host write port to panel pins
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module hub75_top (
    input  logic                   clk_in,
    input  logic                   reset,
    input  logic                   wr_en,
    input  hub75_pkg::fb_addr_t    wr_addr,
    input  hub75_pkg::pixel_pair_t wr_data,
    output logic                   r0,
    output logic                   g0,
    output logic                   b0,
    output logic                   r1,
    output logic                   g1,
    output logic                   b1,
    output logic                   panel_clk,
    output logic                   latch,
    output logic                   oe_n,
    output hub75_pkg::row_addr_t   row_sel
);

    hub75_pkg::col_addr_t   scan_col;
    hub75_pkg::row_addr_t   scan_row;
    hub75_pkg::plane_t      plane;
    logic                   load_start;
    hub75_pkg::fb_addr_t    ram_addr;
    logic                   ram_rd_en;
    hub75_pkg::pixel_pair_t ram_word;
    hub75_pkg::pixel_pair_t pair;
    logic                   pair_valid;

    framebuffer_ram u_ram (
        .clk_in  (clk_in),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (ram_rd_en),
        .rd_addr (ram_addr),
        .rd_data (ram_word)
    );

    scan_control u_scan (
        .clk_in           (clk_in),
        .reset            (reset),
        .column_address   (scan_col),
        .row_address      (scan_row),
        .pixel_load_start (load_start),
        .plane            (plane),
        .latch            (latch),
        .oe_n             (oe_n),
        .row_sel          (row_sel)
    );

    framebuffer_fetch u_fetch (
        .reset            (reset),
        .clk_in           (clk_in),
        .column_address   (scan_col),
        .row_address      (scan_row),
        .pixel_load_start (load_start),
        .ram_data_in      (ram_word),
        .ram_address      (ram_addr),
        .ram_clk_enable   (ram_rd_en),
        .pixel_pair       (pair),
        .pixel_valid      (pair_valid)
    );

    pixel_encoder u_encoder (
        .clk_in      (clk_in),
        .reset       (reset),
        .pixel_pair  (pair),
        .pixel_valid (pair_valid),
        .plane       (plane),
        .r0          (r0),
        .g0          (g0),
        .b0          (b0),
        .r1          (r1),
        .g1          (g1),
        .b1          (b1),
        .panel_clk   (panel_clk)
    );

endmodule

/* src/pixel_encoder.sv */
////////////////////////////////////////////////////////////
// plane bit select for both halves and panel shift clock
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pixel_encoder (
    input  logic                   clk_in,
    input  logic                   reset,
    input  hub75_pkg::pixel_pair_t pixel_pair,
    input  logic                   pixel_valid,
    input  hub75_pkg::plane_t      plane,
    output logic                   r0,
    output logic                   g0,
    output logic                   b0,
    output logic                   r1,
    output logic                   g1,
    output logic                   b1,
    output logic                   panel_clk
);

    logic shift_pending;

    // colour lines settle a cycle before the clock rises
    always_ff @(posedge clk_in) begin
        if (reset) begin
            r0 <= 1'b0;
            g0 <= 1'b0;
            b0 <= 1'b0;
            r1 <= 1'b0;
            g1 <= 1'b0;
            b1 <= 1'b0;
        end else if (pixel_valid) begin
            r0 <= pixel_pair.top.red[plane];
            g0 <= pixel_pair.top.green[plane];
            b0 <= pixel_pair.top.blue[plane];
            r1 <= pixel_pair.bottom.red[plane];
            g1 <= pixel_pair.bottom.green[plane];
            b1 <= pixel_pair.bottom.blue[plane];
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            shift_pending <= 1'b0;
            panel_clk <= 1'b0;
        end else begin
            shift_pending <= pixel_valid;
            panel_clk <= shift_pending;
        end
    end

    // clock only follows a freshly captured pair
    clk_after_pair: assert property (@(posedge clk_in) disable iff (reset)
        panel_clk |-> $past(pixel_valid, 2));

endmodule

/* src/scan_control.sv */
////////////////////////////////////////////////////////////
// scan controller: column loads, blank and latch sequence,
// and the plane weighted led enable window
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "hub75_params.svh"

module scan_control (
    input  logic                 clk_in,
    input  logic                 reset,
    output hub75_pkg::col_addr_t column_address,
    output hub75_pkg::row_addr_t row_address,
    output logic                 pixel_load_start,
    output hub75_pkg::plane_t    plane,
    output logic                 latch,
    output logic                 oe_n,
    output hub75_pkg::row_addr_t row_sel
);

    localparam int LOADS = `HUB75_PANEL_WIDTH;
    localparam int LOAD_W = $clog2(LOADS + 1);
    localparam int ON_MAX = `HUB75_ON_BASE << (`HUB75_COLOR_BITS - 1);
    localparam int TIMER_W = $clog2(ON_MAX);
    // start register, fetch, valid and encoder stages before the last clock ends
    localparam int DRAIN_CYCLES = 5;

    hub75_pkg::scan_state_t state;
    logic [1:0]             slot;
    logic [LOAD_W-1:0]      load_count;
    logic [TIMER_W-1:0]     timer;
    logic                   row_loaded;

    assign row_loaded = (load_count == LOAD_W'(LOADS));

    // leds only lit while displaying
    assign oe_n = (state != hub75_pkg::DISPLAY);
    assign latch = (state == hub75_pkg::LATCH);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= hub75_pkg::SHIFT;
            slot <= '0;
            load_count <= '0;
            timer <= '0;
            column_address <= '0;
            row_address <= '0;
            plane <= '0;
            row_sel <= '0;
            pixel_load_start <= 1'b0;
        end else begin
            pixel_load_start <= 1'b0;
            case (state)
                hub75_pkg::SHIFT: begin
                    slot <= slot + 2'd1;
                    if (!row_loaded && slot == 2'd0) begin
                        // one load per four cycles, column held until the next
                        pixel_load_start <= 1'b1;
                        column_address <= hub75_pkg::col_addr_t'(load_count);
                        load_count <= load_count + 1'b1;
                        if (load_count == LOAD_W'(LOADS - 1)) begin
                            timer <= TIMER_W'(DRAIN_CYCLES);
                        end
                    end else if (row_loaded) begin
                        // wait out the last shift clock
                        if (timer == '0) begin
                            state <= hub75_pkg::BLANK;
                        end else begin
                            timer <= timer - 1'b1;
                        end
                    end
                end
                hub75_pkg::BLANK: begin
                    state <= hub75_pkg::LATCH;
                    row_sel <= row_address;
                end
                hub75_pkg::LATCH: begin
                    state <= hub75_pkg::DISPLAY;
                    timer <= TIMER_W'((`HUB75_ON_BASE << plane) - 1);
                end
                hub75_pkg::DISPLAY: begin
                    if (timer == '0) begin
                        state <= hub75_pkg::SHIFT;
                        slot <= '0;
                        load_count <= '0;
                        plane <= plane + 1'b1;
                        // next row once the last plane is shown
                        if (plane == hub75_pkg::plane_t'(`HUB75_COLOR_BITS - 1)) begin
                            row_address <= row_address + 1'b1;
                        end
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
                default: begin
                    state <= hub75_pkg::SHIFT;
                end
            endcase
        end
    end

    // panel must be dark while the new row is latched
    latch_blanked: assert property (@(posedge clk_in) disable iff (reset)
        latch |-> oe_n);

endmodule

/* tb/hub75_checker.sv */
////////////////////////////////////////////////////////////
// hub75 checker: expected scan order, pixel bits, timing
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "hub75_params.svh"

module hub75_checker (
    input  logic                   clk_in,
    input  logic                   reset,
    input  logic                   wr_en,
    input  hub75_pkg::fb_addr_t    wr_addr,
    input  hub75_pkg::pixel_pair_t wr_data,
    input  logic                   r0,
    input  logic                   g0,
    input  logic                   b0,
    input  logic                   r1,
    input  logic                   g1,
    input  logic                   b1,
    input  logic                   panel_clk,
    input  logic                   latch,
    input  logic                   oe_n,
    input  hub75_pkg::row_addr_t   row_sel,
    input  logic                   image_loaded,
    output int                     latch_total
);

    localparam int DEPTH = 2 ** $bits(hub75_pkg::fb_addr_t);
    localparam int WIDTH = `HUB75_PANEL_WIDTH;
    localparam int TESTS = 6;

    hub75_pkg::pixel_pair_t image [DEPTH];
    hub75_pkg::pixel_pair_t exp_pair;
    hub75_pkg::fb_addr_t    exp_addr;
    hub75_pkg::row_addr_t   exp_row;
    hub75_pkg::plane_t      exp_plane;
    hub75_pkg::plane_t      disp_plane;
    int                     pass_cnt [TESTS];
    int                     fail_cnt [TESTS];
    string                  test_name [TESTS];
    int                     col;
    int                     shift_count;
    int                     on_count;
    logic                   prev_reset;
    logic                   window_live;
    logic                   in_display;

    initial begin
        test_name = '{"reset state", "pixel bits", "shift count", "row order",
                      "plane weighting", "blanking"};
        pass_cnt = '{default: 0};
        fail_cnt = '{default: 0};
        latch_total = 0;
        // outputs are only defined from the second edge of reset on
        prev_reset = 1'b0;
    end

    task automatic record(input int t, input logic ok, input string msg);
        if (ok) begin
            pass_cnt[t]++;
        end else begin
            fail_cnt[t]++;
            $display("FAIL %0t ns: %s", $time, msg);
        end
    endtask

    // top then bottom, red green blue
    function automatic logic [5:0] plane_bits(input hub75_pkg::pixel_pair_t p,
                                              input hub75_pkg::plane_t pl);
        return {p.top.red[pl], p.top.green[pl], p.top.blue[pl],
                p.bottom.red[pl], p.bottom.green[pl], p.bottom.blue[pl]};
    endfunction

    always @(posedge clk_in) begin
        if (wr_en) begin
            image[wr_addr] = wr_data;
        end
        if (prev_reset) begin
            record(0, !panel_clk && !latch && oe_n && {r0, g0, b0, r1, g1, b1} == 6'b0,
                   "panel outputs not idle during or right after reset");
        end
        prev_reset = reset;
        if (reset) begin
            exp_row = '0;
            exp_plane = '0;
            col = 0;
            shift_count = 0;
            on_count = 0;
            window_live = 1'b0;
            in_display = 1'b0;
        end else begin
            if (panel_clk) begin
                record(5, oe_n, "oe_n low while shifting");
                if (window_live && col < WIDTH) begin
                    exp_addr.row = exp_row;
                    exp_addr.col = hub75_pkg::col_addr_t'(col);
                    exp_pair = image[exp_addr];
                    record(1, {r0, g0, b0, r1, g1, b1} == plane_bits(exp_pair, exp_plane),
                           $sformatf("row %0d col %0d plane %0d bits %b, expected %b",
                                     exp_row, col, exp_plane, {r0, g0, b0, r1, g1, b1},
                                     plane_bits(exp_pair, exp_plane)));
                end
                col++;
                shift_count++;
            end
            if (in_display) begin
                if (!oe_n) begin
                    on_count++;
                end else begin
                    record(4, on_count == (`HUB75_ON_BASE << disp_plane),
                           $sformatf("plane %0d on for %0d cycles, expected %0d",
                                     disp_plane, on_count, `HUB75_ON_BASE << disp_plane));
                    in_display = 1'b0;
                end
            end else begin
                // dark from the end of one window to the next latch
                record(5, oe_n, "oe_n low outside the display window");
            end
            if (latch) begin
                record(5, oe_n, "oe_n low while latch high");
                record(2, shift_count == WIDTH,
                       $sformatf("%0d shift clocks before latch, expected %0d",
                                 shift_count, WIDTH));
                record(3, row_sel == exp_row,
                       $sformatf("row_sel %0d at latch, expected %0d", row_sel, exp_row));
                disp_plane = exp_plane;
                in_display = 1'b1;
                on_count = 0;
                shift_count = 0;
                col = 0;
                latch_total++;
                // next window only checked once the whole image is written
                window_live = image_loaded;
                if (exp_plane == hub75_pkg::plane_t'(`HUB75_COLOR_BITS - 1)) begin
                    exp_row = exp_row + 1'b1;
                end
                exp_plane = exp_plane + 1'b1;
            end
        end
    end

    task automatic report(output int failures);
        failures = 0;
        for (int t = 0; t < TESTS; t++) begin
            $display("%-16s %0d checks, %0d failed", test_name[t],
                     pass_cnt[t] + fail_cnt[t], fail_cnt[t]);
            failures += fail_cnt[t];
            if (pass_cnt[t] + fail_cnt[t] == 0) begin
                $display("test %s never ran a single check", test_name[t]);
                failures++;
            end
        end
    endtask

endmodule

/* tb/hub75_tb.sv */
////////////////////////////////////////////////////////////
// hub75 driver testbench: clock, reset, image load, watchdog
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "hub75_params.svh"

module hub75_tb;

    localparam int CLK_PERIOD = 40;
    localparam int DEPTH = 2 ** $bits(hub75_pkg::fb_addr_t);
    localparam int PLANES = `HUB75_COLOR_BITS;
    // four cycles per column plus drain, blank and latch
    localparam int SHIFT_CYCLES = `HUB75_PANEL_WIDTH * 4 + 16;
    localparam int ROW_CYCLES = PLANES * SHIFT_CYCLES
        + `HUB75_ON_BASE * ((1 << PLANES) - 1);
    localparam int FRAME_CYCLES = ROW_CYCLES * `HUB75_HALF_HEIGHT;
    localparam int WATCHDOG_NS = (2 * FRAME_CYCLES + DEPTH + 1000) * CLK_PERIOD;
    // one frame after the image is in, plus two rows
    localparam int TARGET_LATCHES = PLANES * `HUB75_HALF_HEIGHT + 2 * PLANES;

    logic                   clk_in;
    logic                   reset;
    logic                   wr_en;
    hub75_pkg::fb_addr_t    wr_addr;
    hub75_pkg::pixel_pair_t wr_data;
    logic                   r0;
    logic                   g0;
    logic                   b0;
    logic                   r1;
    logic                   g1;
    logic                   b1;
    logic                   panel_clk;
    logic                   latch;
    logic                   oe_n;
    hub75_pkg::row_addr_t   row_sel;
    logic                   image_loaded;
    int                     latch_total;
    int                     failures;

    logic [23:0] image_words [DEPTH];

    hub75_top dut (
        .clk_in    (clk_in),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .r0        (r0),
        .g0        (g0),
        .b0        (b0),
        .r1        (r1),
        .g1        (g1),
        .b1        (b1),
        .panel_clk (panel_clk),
        .latch     (latch),
        .oe_n      (oe_n),
        .row_sel   (row_sel)
    );

    hub75_checker u_check (
        .clk_in       (clk_in),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .r0           (r0),
        .g0           (g0),
        .b0           (b0),
        .r1           (r1),
        .g1           (g1),
        .b1           (b1),
        .panel_clk    (panel_clk),
        .latch        (latch),
        .oe_n         (oe_n),
        .row_sel      (row_sel),
        .image_loaded (image_loaded),
        .latch_total  (latch_total)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns with %0d latches seen", WATCHDOG_NS, latch_total);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        reset = 1'b1;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        image_loaded = 1'b0;
        failures = 0;
        void'($urandom(32'hae09_590b));
        // random background, the vectors file overrides its own words
        for (int i = 0; i < DEPTH; i++) begin
            image_words[i] = 24'($urandom);
        end
        $readmemh("tb/hub75_vectors.txt", image_words);

        repeat (4) @(posedge clk_in);
        reset <= 1'b0;

        for (int i = 0; i < DEPTH; i++) begin
            @(posedge clk_in);
            wr_en <= 1'b1;
            wr_addr <= hub75_pkg::fb_addr_t'(10'(i));
            wr_data <= hub75_pkg::pixel_pair_t'(image_words[i]);
        end
        @(posedge clk_in);
        wr_en <= 1'b0;
        image_loaded <= 1'b1;

        while (latch_total < TARGET_LATCHES) begin
            @(posedge clk_in);
        end
        @(posedge clk_in);

        u_check.report(failures);
        $display("summary: %0d latches, %0d failed checks", latch_total, failures);
        if (failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb/hub75_vectors.txt */
// columns: @address (row in bits 9:6, column in 5:0), then the word
// word: bottom r g b, top r g b, one hex digit each
// tests: reset state, pixel bits, shift count, row order,
// plane weighting, blanking
@000 000000
@001 fff000
@002 000fff
@003 f00f00
@004 0f00f0
@005 00f00f
@03f 123456
@040 a5a5a5
@041 5a5a5a
@07f 888111
@1c0 fedcba
@200 ffffff
@201 000000
@2aa 369c36
@33f 0f0f0f
@3c0 abcdef
@3fe 777777
@3ff 999888
